//--- source/fetch_isa_pkg.sv
package fetch_isa_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] instr_t;
  typedef logic [6:0]  opcode_t;

  localparam opcode_t opcode_branch = 7'b1100011;
  localparam opcode_t opcode_jal    = 7'b1101111;

  localparam addr_t pc_step  = 32'd4;  // sequential fetch
  localparam addr_t reset_pc = 32'd0;

endpackage

//--- source/fetch_pred_pkg.sv
package fetch_pred_pkg;

  // btb index is pc[7:2] and tag is pc[31:8]
  localparam int unsigned btb_entries = 64;
  typedef logic [5:0]  btb_index_t;
  typedef logic [23:0] btb_tag_t;

  // local history table indexed by pc[5:2]
  localparam int unsigned lht_entries = 16;
  typedef logic [3:0] lht_index_t;
  typedef logic [3:0] hist_t;  // newest outcome in bit 0

  localparam int unsigned pattern_count = 16;  // one counter per history
  typedef logic [1:0] counter_t;  // msb set means taken
  localparam counter_t counter_init = 2'b01;  // weak not-taken

  localparam int unsigned queue_depth = 8;
  typedef logic [2:0] queue_ptr_t;
  typedef logic [3:0] queue_count_t;

  localparam int unsigned fetch_credits = 4;
  typedef logic [2:0] credit_t;

  typedef enum logic {
    run,
    redirect
  } fetch_state_t;

endpackage

//--- source/branch_target_buffer.sv
module branch_target_buffer
  import fetch_isa_pkg::*;
  import fetch_pred_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  addr_t lookup_pc,
  output logic  hit,
  output addr_t target,
  input  logic  write_en,
  input  addr_t write_pc,
  input  addr_t write_target
);

  logic [btb_entries-1:0] valid_bits;
  btb_tag_t               tag_mem [btb_entries];
  addr_t                  target_mem [btb_entries];
  btb_index_t             rd_index;
  btb_tag_t               rd_tag;
  btb_index_t             wr_index;
  btb_tag_t               wr_tag;

  assign rd_index = lookup_pc[7:2];
  assign rd_tag   = lookup_pc[31:8];
  assign wr_index = write_pc[7:2];
  assign wr_tag   = write_pc[31:8];

  assign hit    = valid_bits[rd_index] && (tag_mem[rd_index] == rd_tag);
  assign target = target_mem[rd_index];  // only meaningful on hit

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      valid_bits <= '0;
    else if (write_en)
      valid_bits[wr_index] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (write_en)
    begin
      tag_mem[wr_index]    <= wr_tag;
      target_mem[wr_index] <= write_target;
    end
  end

endmodule

//--- source/local_predictor.sv
module local_predictor
  import fetch_isa_pkg::*;
  import fetch_pred_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  addr_t lookup_pc,
  output logic  predict_taken,
  input  logic  train_en,
  input  addr_t train_pc,
  input  logic  train_taken
);

  hist_t      lht [lht_entries];
  counter_t   pht [pattern_count];
  lht_index_t rd_index;
  lht_index_t wr_index;
  hist_t      train_hist;
  counter_t   train_count;
  counter_t   next_count;

  assign rd_index = lookup_pc[5:2];
  assign wr_index = train_pc[5:2];

  assign predict_taken = pht[lht[rd_index]][1];

  assign train_hist  = lht[wr_index];
  assign train_count = pht[train_hist];

  // saturating 2-bit update
  always_comb
  begin
    next_count = train_count;
    if (train_taken && train_count != 2'b11)
      next_count = train_count + 1'b1;
    else if (!train_taken && train_count != 2'b00)
      next_count = train_count - 1'b1;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < lht_entries; i++)
        lht[i] <= '0;
      for (int i = 0; i < pattern_count; i++)
        pht[i] <= counter_init;
    end
    else if (train_en)
    begin
      pht[train_hist] <= next_count;  // counter picked by old history
      lht[wr_index]   <= {train_hist[2:0], train_taken};
    end
  end

endmodule

//--- source/branch_queue.sv
module branch_queue
  import fetch_isa_pkg::*;
  import fetch_pred_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  addr_t push_pc,
  input  logic  push_is_branch,
  input  logic  push_taken,
  input  addr_t push_target,
  output logic  full,
  input  logic  resolve_valid,
  input  logic  resolve_taken,
  input  addr_t resolve_target,
  output logic  mispredict,
  output addr_t correct_pc,
  output logic  btb_write,
  output logic  predictor_train,
  output addr_t train_pc
);

  addr_t        pc_q [queue_depth];
  logic         branch_q [queue_depth];
  logic         taken_q [queue_depth];
  addr_t        target_q [queue_depth];
  queue_ptr_t   rd_ptr;
  queue_ptr_t   wr_ptr;
  queue_count_t count;
  addr_t        head_pc;
  logic         head_taken;
  addr_t        head_target;

  assign head_pc     = pc_q[rd_ptr];
  assign head_taken  = taken_q[rd_ptr];
  assign head_target = target_q[rd_ptr];

  assign full = (count == queue_count_t'(queue_depth));

  // wrong direction, or taken to a different target
  assign mispredict = resolve_valid &&
                      ((resolve_taken != head_taken) ||
                       (resolve_taken && head_target != resolve_target));
  assign correct_pc = resolve_taken ? resolve_target : head_pc + pc_step;

  assign btb_write       = resolve_valid && resolve_taken;
  assign predictor_train = resolve_valid && branch_q[rd_ptr];
  assign train_pc        = head_pc;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else if (mispredict)
    begin
      rd_ptr <= '0;  // flush everything younger
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (resolve_valid)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, resolve_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      pc_q[wr_ptr]     <= push_pc;
      branch_q[wr_ptr] <= push_is_branch;
      taken_q[wr_ptr]  <= push_taken;
      target_q[wr_ptr] <= push_target;
    end
  end

endmodule

//--- source/fetch_control.sv
module fetch_control
  import fetch_isa_pkg::*;
  import fetch_pred_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  output addr_t  imem_addr,
  input  instr_t imem_data,
  input  logic   btb_hit,
  input  addr_t  btb_target,
  input  logic   predict_taken,
  input  logic   queue_full,
  output logic   push,
  output logic   push_is_branch,
  output logic   push_taken,
  output addr_t  push_target,
  input  logic   mispredict,
  input  addr_t  correct_pc,
  input  logic   credit_return,
  output logic   fetch_valid,
  output addr_t  fetch_pc,
  output instr_t fetch_instr,
  output logic   redirect
);

  fetch_state_t state;
  addr_t        pc;
  credit_t      credits;
  opcode_t      opcode;
  logic         is_branch;
  logic         is_jal;
  logic         take;
  logic         fire;
  addr_t        next_pc;

  assign imem_addr = pc;

  assign opcode    = imem_data[6:0];
  assign is_branch = (opcode == opcode_branch);
  assign is_jal    = (opcode == opcode_jal);

  // jal follows any btb hit, a branch also needs the counter
  assign take    = btb_hit && (is_jal || (is_branch && predict_taken));
  assign next_pc = take ? btb_target : pc + pc_step;

  // the cycle of a mispredict fetches nothing
  assign fire = (credits != '0) && !queue_full && !mispredict;

  assign push           = fire && (is_branch || is_jal);
  assign push_is_branch = is_branch;
  assign push_taken     = take;
  assign push_target    = btb_target;

  // high for one cycle after a mispredict
  assign redirect = (state == fetch_pred_pkg::redirect);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= run;
      pc    <= reset_pc;
    end
    else
    begin
      state <= mispredict ? fetch_pred_pkg::redirect : run;
      if (mispredict)
        pc <= correct_pc;
      else if (fire)
        pc <= next_pc;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      credits     <= credit_t'(fetch_credits);
      fetch_valid <= 1'b0;
    end
    else
    begin
      fetch_valid <= fire;
      case ({fire, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;  // usable next cycle
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      fetch_pc    <= pc;
      fetch_instr <= imem_data;
    end
  end

endmodule

//--- source/fetch_unit.sv
module fetch_unit
  import fetch_isa_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  output addr_t  imem_addr,
  input  instr_t imem_data,
  output logic   fetch_valid,
  output addr_t  fetch_pc,
  output instr_t fetch_instr,
  input  logic   credit_return,
  input  logic   resolve_valid,
  input  logic   resolve_taken,
  input  addr_t  resolve_target,
  output logic   redirect
);

  logic  btb_hit;
  addr_t btb_target;
  logic  predict_taken;
  logic  queue_full;
  logic  push;
  logic  push_is_branch;
  logic  push_taken;
  addr_t push_target;
  logic  mispredict;
  addr_t correct_pc;
  logic  btb_write;
  logic  predictor_train;
  addr_t train_pc;

  fetch_control u_control (
    .clk            (clk),
    .rst            (rst),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .btb_hit        (btb_hit),
    .btb_target     (btb_target),
    .predict_taken  (predict_taken),
    .queue_full     (queue_full),
    .push           (push),
    .push_is_branch (push_is_branch),
    .push_taken     (push_taken),
    .push_target    (push_target),
    .mispredict     (mispredict),
    .correct_pc     (correct_pc),
    .credit_return  (credit_return),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr),
    .redirect       (redirect)
  );

  branch_target_buffer u_btb (
    .clk          (clk),
    .rst          (rst),
    .lookup_pc    (imem_addr),  // fetch pc doubles as lookup
    .hit          (btb_hit),
    .target       (btb_target),
    .write_en     (btb_write),
    .write_pc     (train_pc),
    .write_target (resolve_target)
  );

  local_predictor u_predictor (
    .clk           (clk),
    .rst           (rst),
    .lookup_pc     (imem_addr),
    .predict_taken (predict_taken),
    .train_en      (predictor_train),
    .train_pc      (train_pc),
    .train_taken   (resolve_taken)
  );

  branch_queue u_queue (
    .clk             (clk),
    .rst             (rst),
    .push            (push),
    .push_pc         (imem_addr),
    .push_is_branch  (push_is_branch),
    .push_taken      (push_taken),
    .push_target     (push_target),
    .full            (queue_full),
    .resolve_valid   (resolve_valid),
    .resolve_taken   (resolve_taken),
    .resolve_target  (resolve_target),
    .mispredict      (mispredict),
    .correct_pc      (correct_pc),
    .btb_write       (btb_write),
    .predictor_train (predictor_train),
    .train_pc        (train_pc)
  );

endmodule

//--- bench/tb_clock.sv
module tb_clock
(
  output logic clk
);

  localparam int half_period = 2;  // period 4

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

//--- bench/fetch_tb.sv
module fetch_tb
  import fetch_isa_pkg::*;
  import fetch_pred_pkg::*;
();

  localparam int pass_count = 18;
  localparam int max_cycles = pass_count * 165 + 30;  // ~2.5x a normal run
  localparam int loop_trips = 12;  // taken 11 times, then falls out
  localparam addr_t back_jal_pc = 32'h44;

  logic   clk;
  logic   rst;
  addr_t  imem_addr;
  instr_t imem_data;
  logic   fetch_valid;
  addr_t  fetch_pc;
  instr_t fetch_instr;
  logic   credit_return;
  logic   resolve_valid;
  logic   resolve_taken;
  addr_t  resolve_target;
  logic   redirect;

  instr_t prog [32];
  addr_t  jump_to [32];  // taken target of each control word

  // reference tables and their one-cycle-old last_ copies
  logic     btb_valid [btb_entries];
  btb_tag_t btb_tag [btb_entries];
  addr_t    btb_dest [btb_entries];
  hist_t    lht [lht_entries];
  counter_t pht [pattern_count];
  logic     last_btb_valid [btb_entries];
  btb_tag_t last_btb_tag [btb_entries];
  addr_t    last_btb_dest [btb_entries];
  hist_t    last_lht [lht_entries];
  counter_t last_pht [pattern_count];

  // items the execute model still has to resolve
  addr_t pend_pc [$];
  logic  pend_branch [$];
  logic  pend_taken [$];
  addr_t pend_target [$];
  int    pend_due [$];
  int    credit_due [$];

  addr_t res_pc;
  logic  res_branch;
  logic  res_taken;
  addr_t res_target;
  addr_t expect_pc;
  logic  expect_redirect;
  int    cyc;
  int    outstanding;
  int    loop_iter;
  int    passes_done;
  int    last_credit;
  int    last_resolve;
  int    cold_redirects;
  int    exit_redirects;
  int    loop_hits;
  int    jal_hits;

  tb_clock u_clock (
    .clk (clk)
  );

  fetch_unit u_dut (
    .clk            (clk),
    .rst            (rst),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr),
    .credit_return  (credit_return),
    .resolve_valid  (resolve_valid),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .redirect       (redirect)
  );

  assign imem_data = prog[imem_addr[6:2]];  // same-cycle read

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_with_failure($sformatf("mismatch %s expected %h actual %h", test, expected, actual));
  endtask

  task automatic age_tables();
    last_btb_valid = btb_valid;
    last_btb_tag   = btb_tag;
    last_btb_dest  = btb_dest;
    last_lht       = lht;
    last_pht       = pht;
  endtask

  task automatic predict(input addr_t pc, input instr_t instr, output logic take,
                         output addr_t dest);
    logic hit;
    logic is_branch;
    hit       = last_btb_valid[pc[7:2]] && (last_btb_tag[pc[7:2]] == pc[31:8]);
    is_branch = (instr[6:0] == opcode_branch);
    take      = hit && ((instr[6:0] == opcode_jal) ||
                        (is_branch && last_pht[last_lht[pc[5:2]]][1]));
    dest      = last_btb_dest[pc[7:2]];
  endtask

  task automatic train(input addr_t pc, input logic is_branch, input logic taken,
                       input addr_t dest);
    hist_t    h;
    counter_t c;
    if (taken)
    begin
      btb_valid[pc[7:2]] = 1'b1;
      btb_tag[pc[7:2]]   = pc[31:8];
      btb_dest[pc[7:2]]  = dest;
    end
    if (is_branch)
    begin
      h = lht[pc[5:2]];
      c = pht[h];
      if (taken && c != 2'b11)
        c = c + 1'b1;
      else if (!taken && c != 2'b00)
        c = c - 1'b1;
      pht[h]         = c;
      lht[pc[5:2]]   = {h[2:0], taken};
    end
  endtask

  task automatic check_cycle();
    logic  take;
    addr_t dest;
    logic  is_ctrl;
    int    due;
    assert (redirect == expect_redirect)
      else report_mismatch("redirect", expect_redirect, redirect);
    assert (!(redirect && fetch_valid))
      else stop_with_failure("fetch_valid was high in the redirect cycle");
    expect_redirect = 1'b0;
    outstanding = outstanding + int'(fetch_valid) - int'(credit_return);
    assert (outstanding <= fetch_credits)
      else stop_with_failure("more items outstanding than fetch credits");
    if (fetch_valid)
    begin
      assert (fetch_pc == expect_pc)
        else report_mismatch("fetch_pc", expect_pc, fetch_pc);
      assert (fetch_instr == prog[fetch_pc[6:2]])
        else report_mismatch("fetch_instr", prog[fetch_pc[6:2]], fetch_instr);
      predict(fetch_pc, fetch_instr, take, dest);
      expect_pc = take ? dest : fetch_pc + pc_step;
      due = cyc + 1 + int'($urandom % 4);  // decoder credit delay 0..3
      last_credit = (due > last_credit) ? due : last_credit + 1;
      credit_due.push_back(last_credit);
      is_ctrl = (fetch_instr[6:0] == opcode_branch) || (fetch_instr[6:0] == opcode_jal);
      if (is_ctrl)
      begin
        due = cyc + 1 + int'($urandom % 4);
        last_resolve = (due > last_resolve) ? due : last_resolve + 1;
        pend_pc.push_back(fetch_pc);
        pend_branch.push_back(fetch_instr[6:0] == opcode_branch);
        pend_taken.push_back(take);
        pend_target.push_back(dest);
        pend_due.push_back(last_resolve);
        if (take && fetch_instr[6:0] == opcode_branch)
          loop_hits++;
        else if (take)
          jal_hits++;
      end
    end
    // the pc being looked up is the next one to be fetched
    assert (imem_addr == expect_pc)
      else report_mismatch("imem_addr", expect_pc, imem_addr);
    age_tables();
    if (resolve_valid)
    begin
      train(res_pc, res_branch, resolve_taken, resolve_target);
      if ((resolve_taken != res_taken) || (resolve_taken && resolve_target != res_target))
      begin
        expect_pc       = resolve_taken ? resolve_target : res_pc + pc_step;
        expect_redirect = 1'b1;
        pend_pc.delete();  // decoder drops everything unresolved
        pend_branch.delete();
        pend_taken.delete();
        pend_target.delete();
        pend_due.delete();
        if (res_branch && resolve_taken)
          cold_redirects++;
        else if (res_branch)
          exit_redirects++;
      end
    end
  endtask

  task automatic drive_inputs();
    credit_return = 1'b0;
    resolve_valid = 1'b0;
    if (credit_due.size() > 0 && credit_due[0] <= cyc)
    begin
      void'(credit_due.pop_front());
      credit_return = 1'b1;
    end
    if (pend_due.size() > 0 && pend_due[0] <= cyc)
    begin
      void'(pend_due.pop_front());
      res_pc     = pend_pc.pop_front();
      res_branch = pend_branch.pop_front();
      res_taken  = pend_taken.pop_front();
      res_target = pend_target.pop_front();
      if (res_branch)
      begin
        loop_iter++;
        resolve_taken = (loop_iter % loop_trips) != 0;
      end
      else
        resolve_taken = 1'b1;  // jal
      resolve_target = jump_to[res_pc[6:2]];
      resolve_valid  = 1'b1;
      if (res_pc == back_jal_pc)
        passes_done++;
    end
  endtask

  initial
  begin
    for (int i = 0; i < 32; i++)
    begin
      prog[i]    = {12'(i * 4), 13'd0, 7'b0010011};  // addi x0, x0, addr
      jump_to[i] = '0;
    end
    prog[6]     = {25'h0, opcode_branch};  // 0x18 loops back to 0x10
    jump_to[6]  = 32'h10;
    prog[7]     = {25'h0, opcode_jal};
    jump_to[7]  = 32'h40;
    prog[17]    = {25'h0, opcode_jal};  // 0x44 restarts the program
    jump_to[17] = reset_pc;
    for (int i = 0; i < btb_entries; i++)
      btb_valid[i] = 1'b0;
    for (int i = 0; i < lht_entries; i++)
      lht[i] = '0;
    for (int i = 0; i < pattern_count; i++)
      pht[i] = counter_init;
    age_tables();
    rst             = 1'b1;
    credit_return   = 1'b0;
    resolve_valid   = 1'b0;
    resolve_taken   = 1'b0;
    resolve_target  = '0;
    void'($urandom(66));
    expect_pc       = reset_pc;
    expect_redirect = 1'b0;
    cyc             = 0;
    outstanding     = 0;
    loop_iter       = 0;
    passes_done     = 0;
    last_credit     = 0;
    last_resolve    = 0;
    cold_redirects  = 0;
    exit_redirects  = 0;
    loop_hits       = 0;
    jal_hits        = 0;
    repeat (16)
    begin
      @(posedge clk);
      #1;
      assert (!fetch_valid && !redirect)
        else stop_with_failure("fetch_valid or redirect was high during reset");
    end
    rst = 1'b0;
    while (passes_done < pass_count)
    begin
      @(posedge clk);
      check_cycle();
      cyc++;
      if (cyc >= max_cycles)
        stop_with_failure("timeout, the program did not finish its passes");
      #1;
      drive_inputs();
    end
    if (cold_redirects > 0 && exit_redirects > 0 && loop_hits > 0 && jal_hits > 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
      stop_with_failure("not every fetch behavior was reached");
  end

endmodule

//--- compile.f
source/fetch_isa_pkg.sv
source/fetch_pred_pkg.sv
source/branch_target_buffer.sv
source/local_predictor.sv
source/branch_queue.sv
source/fetch_control.sv
source/fetch_unit.sv
bench/tb_clock.sv
bench/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - source/fetch_isa_pkg.sv
  - source/fetch_pred_pkg.sv
  - source/branch_target_buffer.sv
  - source/local_predictor.sv
  - source/branch_queue.sv
  - source/fetch_control.sv
  - source/fetch_unit.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/fetch_tb.sv
